// File: tb.f
+incdir+logic
logic/host_pkg.sv
logic/host_ctrl.sv
logic/host_param_regs.sv
logic/host_finish.sv
logic/host_console_fifo.sv
logic/host_watchdog.sv
logic/host_top.sv
verif/host_clk_gen.sv
verif/host_tb.sv

// File: Bender.yml
package:
  name: host_device

export_include_dirs:
  - logic

sources:
  - logic/host_pkg.sv
  - logic/host_ctrl.sv
  - logic/host_param_regs.sv
  - logic/host_finish.sv
  - logic/host_console_fifo.sv
  - logic/host_watchdog.sv
  - logic/host_top.sv
  - target: test
    files:
      - verif/host_clk_gen.sv
      - verif/host_tb.sv

// File: verif/host_tb.sv
// Host device testbench: AXI4-Lite stimulus, reference model,
// continuous output compare and console byte checks
`timescale 1ns/1ps
`include "host_macros.svh"

module host_tb;

  localparam int NH     = `HOST_NUM_HARTS;
  localparam int LIMIT  = `HOST_WDOG_LIMIT;
  localparam int NBYTES = 3 * `HOST_FIFO_DEPTH;
  // Reset, then tests 1 to 6 in cycles
  localparam int TEST_CYCLES = 20 + 20 + 80 + 12 * NH + 8 * NBYTES + 60 + 4 * 100 + 2 * LIMIT;
  localparam int MAX_CYCLES  = 3 * TEST_CYCLES;

  logic                    clk_i;
  logic                    rst_n_i = 1'b0;
  logic [`HOST_ADDR_W-1:0] awaddr_i = '0;
  logic                    awvalid_i = 1'b0;
  logic                    awready_o;
  logic [`HOST_DATA_W-1:0] wdata_i = '0;
  logic                    wvalid_i = 1'b0;
  logic                    wready_o;
  logic [1:0]              bresp_o;
  logic                    bvalid_o;
  logic                    bready_i = 1'b0;
  logic [`HOST_ADDR_W-1:0] araddr_i = '0;
  logic                    arvalid_i = 1'b0;
  logic                    arready_o;
  logic [`HOST_DATA_W-1:0] rdata_o;
  logic [1:0]              rresp_o;
  logic                    rvalid_o;
  logic                    rready_i = 1'b0;
  host_pkg::trace_en_t     trace_en_o;
  logic [NH-1:0]           finish_o;
  logic                    all_done_o;
  logic [7:0]              console_data_o;
  logic                    console_valid_o;
  logic                    console_ready_i = 1'b0;
  logic                    timeout_o;

  // Reference model state
  host_pkg::trace_en_t m_trace = '0;
  logic [NH-1:0]       m_finish = '0;
  logic                m_timeout = 1'b0;
  logic [7:0]          exp_q [$];
  int unsigned         cyc = 0;
  int unsigned         hb_mark = 0;
  logic [31:0]         rng = 32'h51d9_64ed;
  logic [31:0]         stall_rng = 32'h51d9_64ed ^ 32'hffff_0000;
  logic                stall_en = 1'b0;

  host_clk_gen host_clk_gen_inst (.clk_o(clk_i));

  host_top host_top_inst (.*);

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  // Expected {resp, data} of a read
  function automatic logic [33:0] ref_read(input logic [7:0] addr);
    host_pkg::host_status_t st;
    st            = '0;
    st.finish     = m_finish;
    st.all_done   = &m_finish;
    st.fifo_count = host_pkg::fifo_count_t'(exp_q.size());
    st.timeout    = m_timeout;
    case (addr)
      `HOST_ADDR_TRACE_EN: return {`HOST_RESP_OKAY, 32'(m_trace)};
      `HOST_ADDR_STATUS:   return {`HOST_RESP_OKAY, 32'(st)};
      default:             return {`HOST_RESP_SLVERR, 32'h0};
    endcase
  endfunction

  function automatic logic [1:0] ref_wr_resp(input logic [7:0] addr);
    case (addr)
      `HOST_ADDR_TRACE_EN, `HOST_ADDR_FINISH, `HOST_ADDR_PUTCHAR, `HOST_ADDR_HEARTBEAT:
        return `HOST_RESP_OKAY;
      default:
        return `HOST_RESP_SLVERR;
    endcase
  endfunction

  // Model update at the write handshake edge
  task automatic apply_write(input logic [7:0] addr, input logic [31:0] data);
    int id;
    id = int'(data & ((32'd1 << $clog2(NH)) - 1));
    case (addr)
      `HOST_ADDR_TRACE_EN:  m_trace = host_pkg::trace_en_t'(data[10:0]);
      `HOST_ADDR_FINISH:    if (id < NH) m_finish[id] = 1'b1;
      `HOST_ADDR_PUTCHAR:   exp_q.push_back(data[7:0]);
      `HOST_ADDR_HEARTBEAT: hb_mark = cyc;
      default:              ;
    endcase
  endtask

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("*** FAILED ***");
    $fatal(1, "host_tb stopped on first error");
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] want, got);
    fail_run($sformatf("CHECK FAILED at %0t: %s expected %h, actual %h", $time, name, want, got));
  endtask

  task automatic check_trace_en(input string name, input host_pkg::trace_en_t want, got);
    if (got !== want)
      report_mismatch(name, 32'(want), 32'(got));
  endtask

  task automatic check_status(input string name, input host_pkg::host_status_t want, got);
    if (got !== want)
      report_mismatch(name, 32'(want), 32'(got));
  endtask

  task automatic check_resp(input string name, input logic [1:0] want, got);
    if (got !== want)
      report_mismatch(name, 32'(want), 32'(got));
  endtask

  task automatic check_byte(input string name, input logic [7:0] want, got);
    if (got !== want)
      report_mismatch(name, 32'(want), 32'(got));
  endtask

  task automatic check_word(input string name, input logic [31:0] want, got);
    if (got !== want)
      report_mismatch(name, want, got);
  endtask

  task automatic check_bit(input string name, input logic want, got);
    if (got !== want)
      report_mismatch(name, 32'(want), 32'(got));
  endtask

  task automatic axi_write(input logic [7:0] addr, input logic [31:0] data);
    @(posedge clk_i);
    awaddr_i  <= addr;
    wdata_i   <= data;
    awvalid_i <= 1'b1;
    wvalid_i  <= 1'b1;
    bready_i  <= 1'b1;
    do
      @(negedge clk_i);
    while (!awready_o);
    // Address and data channels accept together
    check_bit("wready_o", 1'b1, wready_o);
    @(posedge clk_i);
    awvalid_i <= 1'b0;
    wvalid_i  <= 1'b0;
    apply_write(addr, data);
    @(negedge clk_i);
    if (!bvalid_o)
      fail_run("No write response one cycle after the write handshake");
    else
      check_resp("bresp_o", ref_wr_resp(addr), bresp_o);
  endtask

  task automatic axi_read_check(input logic [7:0] addr, input string name);
    logic [33:0] expd;
    @(posedge clk_i);
    araddr_i  <= addr;
    arvalid_i <= 1'b1;
    rready_i  <= 1'b1;
    do
      @(negedge clk_i);
    while (!arready_o);
    @(posedge clk_i);
    arvalid_i <= 1'b0;
    expd = ref_read(addr);
    @(negedge clk_i);
    if (!rvalid_o)
      fail_run("No read response one cycle after the read handshake");
    else
    begin
      check_resp("rresp_o", expd[33:32], rresp_o);
      // R response pending blocks the next address
      check_bit("arready_o", 1'b0, arready_o);
    end
    if (addr == `HOST_ADDR_STATUS)
      check_status(name, host_pkg::host_status_t'(expd[31:0]), host_pkg::host_status_t'(rdata_o));
    else
      check_word(name, expd[31:0], rdata_o);
  endtask

  // Cycle count, watchdog model, output compare and run limit
  always @(negedge clk_i)
  begin
    cyc = cyc + 1;
    if (cyc > MAX_CYCLES)
      fail_run("Run limit reached without finishing the tests, the DUT stopped responding");
    else if (rst_n_i)
    begin
      if (cyc >= hb_mark + LIMIT)
        m_timeout = 1'b1;
      check_trace_en("trace_en_o", m_trace, trace_en_o);
      check_word("finish_o", 32'(m_finish), 32'(finish_o));
      check_bit("all_done_o", &m_finish, all_done_o);
      check_bit("timeout_o", m_timeout, timeout_o);
    end
  end

  // Console sink with random stalls
  always @(posedge clk_i)
  begin
    stall_rng = xorshift(stall_rng);
    console_ready_i <= stall_en ? (stall_rng[1:0] == 2'b00) : 1'b1;
  end

  always @(negedge clk_i)
  begin
    if (rst_n_i && console_valid_o && console_ready_i)
    begin
      if (exp_q.size() == 0)
        fail_run("Console byte appeared with none left to expect");
      else
        check_byte("console_data_o", exp_q.pop_front(), console_data_o);
    end
  end

  initial
  begin
    int order [NH];
    int j;
    int tmp;
    int k;
    repeat (16)
      @(posedge clk_i);
    rst_n_i <= 1'b1;
    // Watchdog starts counting on the first edge after release
    hb_mark = cyc + 1;
    @(negedge clk_i);

    check_bit("bvalid_o", 1'b0, bvalid_o);
    check_bit("rvalid_o", 1'b0, rvalid_o);
    check_bit("console_valid_o", 1'b0, console_valid_o);
    axi_read_check(`HOST_ADDR_STATUS, "status read");

    axi_write(`HOST_ADDR_HEARTBEAT, rng);
    repeat (6)
    begin
      rng = xorshift(rng);
      axi_write(`HOST_ADDR_TRACE_EN, rng);
      axi_read_check(`HOST_ADDR_TRACE_EN, "trace_en read");
    end

    axi_write(`HOST_ADDR_HEARTBEAT, rng);
    foreach (order[i])
      order[i] = i;
    for (int i = NH - 1; i > 0; i--)
    begin
      rng = xorshift(rng);
      j = rng % (i + 1);
      tmp = order[i];
      order[i] = order[j];
      order[j] = tmp;
    end
    foreach (order[i])
    begin
      rng = xorshift(rng);
      axi_write(`HOST_ADDR_FINISH, {rng[23:0], 8'(order[i])});
      axi_read_check(`HOST_ADDR_STATUS, "status read");
    end

    axi_write(`HOST_ADDR_HEARTBEAT, rng);
    stall_en = 1'b1;
    for (int i = 0; i < NBYTES; i++)
    begin
      rng = xorshift(rng);
      axi_write(`HOST_ADDR_PUTCHAR, rng);
      if (i % 8 == 7)
        axi_write(`HOST_ADDR_HEARTBEAT, rng);
    end
    while (exp_q.size() != 0)
      @(posedge clk_i);
    @(negedge clk_i);
    stall_en = 1'b0;

    axi_write(`HOST_ADDR_HEARTBEAT, rng);
    for (int i = 0; i < 4; i++)
    begin
      rng = xorshift(rng);
      axi_write(8'h14 + 8'(i * 60), rng);
      axi_read_check(8'h14 + 8'(i * 60), "unmapped read");
    end
    axi_write(`HOST_ADDR_STATUS, rng);
    axi_read_check(`HOST_ADDR_PUTCHAR, "write-only read");

    // Handshake edges land 100 cycles apart
    repeat (4)
    begin
      axi_write(`HOST_ADDR_HEARTBEAT, rng);
      repeat (98)
        @(posedge clk_i);
    end
    axi_write(`HOST_ADDR_HEARTBEAT, rng);
    // Strobe cycle began one edge before the handshake edge
    k = 1;
    while (!timeout_o && k < 2 * LIMIT)
    begin
      @(negedge clk_i);
      k++;
    end
    check_word("timeout_o delay", LIMIT, k);
    repeat (20)
      @(negedge clk_i);
    check_bit("timeout_o", 1'b1, timeout_o);

    $display("*** PASSED ***");
    $finish;
  end

endmodule

// File: verif/host_clk_gen.sv
// Testbench clock source, 20 ns period
`timescale 1ns/1ps

module host_clk_gen (
  output logic clk_o
);

  initial
  begin
    clk_o = 1'b0;
    forever
      #10 clk_o = ~clk_o;
  end

endmodule

// File: logic/host_top.sv
// Host device top: AXI4-Lite control plus trace, finish,
// console and watchdog blocks
`timescale 1ns/1ps
`include "host_macros.svh"

module host_top (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic [`HOST_ADDR_W-1:0]    awaddr_i,
  input  logic                       awvalid_i,
  output logic                       awready_o,
  input  logic [`HOST_DATA_W-1:0]    wdata_i,
  input  logic                       wvalid_i,
  output logic                       wready_o,
  output logic [1:0]                 bresp_o,
  output logic                       bvalid_o,
  input  logic                       bready_i,
  input  logic [`HOST_ADDR_W-1:0]    araddr_i,
  input  logic                       arvalid_i,
  output logic                       arready_o,
  output logic [`HOST_DATA_W-1:0]    rdata_o,
  output logic [1:0]                 rresp_o,
  output logic                       rvalid_o,
  input  logic                       rready_i,
  output host_pkg::trace_en_t        trace_en_o,
  output logic [`HOST_NUM_HARTS-1:0] finish_o,
  output logic                       all_done_o,
  output logic [7:0]                 console_data_o,
  output logic                       console_valid_o,
  input  logic                       console_ready_i,
  output logic                       timeout_o
);

  host_pkg::host_wr_t    wr;
  host_pkg::host_status_t status;
  host_pkg::fifo_count_t fifo_count;
  logic                  fifo_full;

  // Status word seen by STATUS reads
  assign status.pad        = '0;
  assign status.timeout    = timeout_o;
  assign status.fifo_count = fifo_count;
  assign status.all_done   = all_done_o;
  assign status.finish     = finish_o;

  host_ctrl host_ctrl_inst (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .awaddr_i    (awaddr_i),
    .awvalid_i   (awvalid_i),
    .awready_o   (awready_o),
    .wdata_i     (wdata_i),
    .wvalid_i    (wvalid_i),
    .wready_o    (wready_o),
    .bresp_o     (bresp_o),
    .bvalid_o    (bvalid_o),
    .bready_i    (bready_i),
    .araddr_i    (araddr_i),
    .arvalid_i   (arvalid_i),
    .arready_o   (arready_o),
    .rdata_o     (rdata_o),
    .rresp_o     (rresp_o),
    .rvalid_o    (rvalid_o),
    .rready_i    (rready_i),
    .wr_o        (wr),
    .trace_en_i  (trace_en_o),
    .status_i    (status),
    .fifo_full_i (fifo_full)
  );

  host_param_regs host_param_regs_inst (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .wr_i       (wr),
    .trace_en_o (trace_en_o)
  );

  host_finish host_finish_inst (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .wr_i       (wr),
    .finish_o   (finish_o),
    .all_done_o (all_done_o)
  );

  host_console_fifo host_console_fifo_inst (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .wr_i    (wr),
    .data_o  (console_data_o),
    .valid_o (console_valid_o),
    .ready_i (console_ready_i),
    .full_o  (fifo_full),
    .count_o (fifo_count)
  );

  host_watchdog host_watchdog_inst (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .wr_i      (wr),
    .timeout_o (timeout_o)
  );

endmodule

// File: logic/host_watchdog.sv
// Heartbeat watchdog with sticky timeout
`timescale 1ns/1ps
`include "host_macros.svh"

module host_watchdog (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  host_pkg::host_wr_t wr_i,
  output logic               timeout_o
);

  localparam int CNT_W = $clog2(`HOST_WDOG_LIMIT + 1);

  logic [CNT_W-1:0] cnt_q;
  logic [CNT_W-1:0] cnt_d;
  logic             timeout_q;

  // Strobe cycle counts as the first idle cycle; counting stops once fired
  always_comb
  begin
    if (wr_i.heartbeat)
      cnt_d = CNT_W'(1);
    else if (timeout_q)
      cnt_d = cnt_q;
    else
      cnt_d = cnt_q + 1'b1;
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      cnt_q     <= '0;
      timeout_q <= 1'b0;
    end
    else
    begin
      cnt_q <= cnt_d;
      if (32'(cnt_d) == `HOST_WDOG_LIMIT)
        timeout_q <= 1'b1;
    end
  end

  assign timeout_o = timeout_q;

endmodule

// File: logic/host_console_fifo.sv
// Console byte FIFO, ready/valid output with fill count
`timescale 1ns/1ps
`include "host_macros.svh"

module host_console_fifo (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  host_pkg::host_wr_t    wr_i,
  output logic [7:0]            data_o,
  output logic                  valid_o,
  input  logic                  ready_i,
  output logic                  full_o,
  output host_pkg::fifo_count_t count_o
);

  localparam int DEPTH = `HOST_FIFO_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  logic [7:0]            mem [DEPTH];
  logic [PTR_W-1:0]      wr_ptr_q;
  logic [PTR_W-1:0]      rd_ptr_q;
  host_pkg::fifo_count_t count_q;
  logic                  push;
  logic                  pop;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (32'(ptr) == DEPTH - 1) ? '0 : ptr + 1'b1;
  endfunction

  assign push = wr_i.putchar;
  assign pop  = valid_o && ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (pop)
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      if (push && !pop)
        count_q <= count_q + 1'b1;
      else if (pop && !push)
        count_q <= count_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (push)
      mem[wr_ptr_q] <= wr_i.data[7:0];
  end

  assign data_o  = mem[rd_ptr_q];
  assign valid_o = (count_q != '0);
  assign full_o  = (32'(count_q) == DEPTH);
  assign count_o = count_q;

  // Back-pressure upstream must hold PUTCHAR off
  a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    full_o |-> !push);

endmodule

// File: logic/host_finish.sv
// Per-hart finish recording and all-done flag
`timescale 1ns/1ps
`include "host_macros.svh"

module host_finish (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  host_pkg::host_wr_t         wr_i,
  output logic [`HOST_NUM_HARTS-1:0] finish_o,
  output logic                       all_done_o
);

  localparam int ID_W = (`HOST_NUM_HARTS > 1) ? $clog2(`HOST_NUM_HARTS) : 1;

  logic [`HOST_NUM_HARTS-1:0] finish_q;
  logic [ID_W-1:0]            hart_id;
  logic                       id_ok;

  assign hart_id = wr_i.data[ID_W-1:0];
  // Ids past the last hart fall away silently
  assign id_ok   = 32'(hart_id) < `HOST_NUM_HARTS;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      finish_q <= '0;
    else if (wr_i.finish && id_ok)
      finish_q[hart_id] <= 1'b1;
  end

  assign finish_o   = finish_q;
  assign all_done_o = &finish_q;

  // Finish bits only ever set, so done must stick
  a_done_sticky: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    all_done_o |=> all_done_o);

endmodule

// File: logic/host_param_regs.sv
// Trace-enable register bank
`timescale 1ns/1ps

module host_param_regs (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  host_pkg::host_wr_t  wr_i,
  output host_pkg::trace_en_t trace_en_o
);

  localparam int EN_W = $bits(host_pkg::trace_en_t);

  host_pkg::trace_en_t trace_en_q;

  // Low data bits map field by field, icache first
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      trace_en_q <= '0;
    else if (wr_i.trace_en)
      trace_en_q <= host_pkg::trace_en_t'(wr_i.data[EN_W-1:0]);
  end

  assign trace_en_o = trace_en_q;

endmodule

// File: logic/host_ctrl.sv
// AXI4-Lite slave front end: address decode, write strobes,
// B and R response sequencing
`timescale 1ns/1ps
`include "host_macros.svh"

module host_ctrl (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic [`HOST_ADDR_W-1:0]  awaddr_i,
  input  logic                     awvalid_i,
  output logic                     awready_o,
  input  logic [`HOST_DATA_W-1:0]  wdata_i,
  input  logic                     wvalid_i,
  output logic                     wready_o,
  output logic [1:0]               bresp_o,
  output logic                     bvalid_o,
  input  logic                     bready_i,
  input  logic [`HOST_ADDR_W-1:0]  araddr_i,
  input  logic                     arvalid_i,
  output logic                     arready_o,
  output logic [`HOST_DATA_W-1:0]  rdata_o,
  output logic [1:0]               rresp_o,
  output logic                     rvalid_o,
  input  logic                     rready_i,
  output host_pkg::host_wr_t       wr_o,
  input  host_pkg::trace_en_t      trace_en_i,
  input  host_pkg::host_status_t   status_i,
  input  logic                     fifo_full_i
);

  function automatic host_pkg::host_reg_e decode_addr(input logic [`HOST_ADDR_W-1:0] addr);
    case (addr)
      `HOST_ADDR_TRACE_EN:  return host_pkg::TRACE_EN;
      `HOST_ADDR_FINISH:    return host_pkg::FINISH;
      `HOST_ADDR_PUTCHAR:   return host_pkg::PUTCHAR;
      `HOST_ADDR_STATUS:    return host_pkg::STATUS;
      `HOST_ADDR_HEARTBEAT: return host_pkg::HEARTBEAT;
      default:              return host_pkg::NONE;
    endcase
  endfunction

  host_pkg::host_reg_e wr_reg;
  host_pkg::host_reg_e rd_reg;
  logic                wr_fire;
  logic                rd_fire;
  logic                bvalid_q;
  logic                rvalid_q;
  logic [1:0]          bresp_q;
  logic [1:0]          rresp_q;
  logic [`HOST_DATA_W-1:0] rdata_q;

  assign wr_reg = decode_addr(awaddr_i);
  assign rd_reg = decode_addr(araddr_i);

  // Address and data are taken together; a full FIFO holds back only PUTCHAR
  assign wr_fire = awvalid_i && wvalid_i && !bvalid_q
                   && !(wr_reg == host_pkg::PUTCHAR && fifo_full_i);
  assign awready_o = wr_fire;
  assign wready_o  = wr_fire;

  assign arready_o = !rvalid_q;
  assign rd_fire   = arvalid_i && !rvalid_q;

  always_comb
  begin
    wr_o      = '0;
    wr_o.data = wdata_i;
    if (wr_fire)
    begin
      case (wr_reg)
        host_pkg::TRACE_EN:  wr_o.trace_en  = 1'b1;
        host_pkg::FINISH:    wr_o.finish    = 1'b1;
        host_pkg::PUTCHAR:   wr_o.putchar   = 1'b1;
        host_pkg::STATUS:    wr_o.status    = 1'b1;
        host_pkg::HEARTBEAT: wr_o.heartbeat = 1'b1;
        default:             ;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
    end
    else
    begin
      if (wr_fire)
        bvalid_q <= 1'b1;
      else if (bready_i)
        bvalid_q <= 1'b0;
      if (rd_fire)
        rvalid_q <= 1'b1;
      else if (rready_i)
        rvalid_q <= 1'b0;
    end
  end

  // Response payloads, loaded on the handshake
  always_ff @(posedge clk_i)
  begin
    if (wr_fire)
    begin
      // STATUS is read-only
      if (wr_reg == host_pkg::NONE || wr_reg == host_pkg::STATUS)
        bresp_q <= `HOST_RESP_SLVERR;
      else
        bresp_q <= `HOST_RESP_OKAY;
    end
    if (rd_fire)
    begin
      case (rd_reg)
        host_pkg::TRACE_EN:
        begin
          rdata_q <= `HOST_DATA_W'(trace_en_i);
          rresp_q <= `HOST_RESP_OKAY;
        end
        host_pkg::STATUS:
        begin
          rdata_q <= `HOST_DATA_W'(status_i);
          rresp_q <= `HOST_RESP_OKAY;
        end
        // Unmapped and write-only registers
        default:
        begin
          rdata_q <= '0;
          rresp_q <= `HOST_RESP_SLVERR;
        end
      endcase
    end
  end

  assign bvalid_o = bvalid_q;
  assign bresp_o  = bresp_q;
  assign rvalid_o = rvalid_q;
  assign rresp_o  = rresp_q;
  assign rdata_o  = rdata_q;

  a_bvalid_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    bvalid_o && !bready_i |=> bvalid_o && $stable(bresp_o));

  a_one_strobe: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0({wr_o.trace_en, wr_o.finish, wr_o.putchar, wr_o.status, wr_o.heartbeat}));

endmodule

// File: logic/host_pkg.sv
// Shared types of the host device: trace enables, register decode,
// write strobes and status word
`include "host_macros.svh"

package host_pkg;

  // Icache sits at bit 0 of the data word
  typedef struct packed {
    logic cosim;
    logic br_prof;
    logic pc_prof;
    logic core_prof;
    logic cmt;
    logic vm;
    logic dram;
    logic cce;
    logic lce;
    logic dcache;
    logic icache;
  } trace_en_t;

  typedef enum logic [2:0] {
    NONE      = 3'd0,
    TRACE_EN  = 3'd1,
    FINISH    = 3'd2,
    PUTCHAR   = 3'd3,
    STATUS    = 3'd4,
    HEARTBEAT = 3'd5
  } host_reg_e;

  // One strobe per decoded register, each high for a single cycle
  typedef struct packed {
    logic                    trace_en;
    logic                    finish;
    logic                    putchar;
    logic                    status;
    logic                    heartbeat;
    logic [`HOST_DATA_W-1:0] data;
  } host_wr_t;

  // Console FIFO fill level, 0 up to the full depth
  typedef logic [$clog2(`HOST_FIFO_DEPTH + 1)-1:0] fifo_count_t;

  typedef struct packed {
    logic [`HOST_DATA_W - `HOST_NUM_HARTS - $bits(fifo_count_t) - 3:0] pad;
    logic                       timeout;
    fifo_count_t                fifo_count;
    logic                       all_done;
    logic [`HOST_NUM_HARTS-1:0] finish;
  } host_status_t;

endpackage

// File: logic/host_macros.svh
// Host device constants: sizes, register offsets, AXI widths
// and response codes
`ifndef HOST_MACROS_SVH
`define HOST_MACROS_SVH

// Harts that can report finish
`define HOST_NUM_HARTS 4

// Console buffer entries
`define HOST_FIFO_DEPTH 8

// Idle cycles before the watchdog fires
`define HOST_WDOG_LIMIT 200

// AXI4-Lite widths
`define HOST_ADDR_W 8
`define HOST_DATA_W 32

// Register byte offsets
`define HOST_ADDR_TRACE_EN  8'h00
`define HOST_ADDR_FINISH    8'h04
`define HOST_ADDR_PUTCHAR   8'h08
`define HOST_ADDR_STATUS    8'h0C
`define HOST_ADDR_HEARTBEAT 8'h10

// AXI response codes
`define HOST_RESP_OKAY   2'b00
`define HOST_RESP_SLVERR 2'b10

`endif
